/* src/axil_macros.svh */
`ifndef AXIL_MACROS_SVH
`define AXIL_MACROS_SVH

// Bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// Register file size and value after reset
`define AXIL_REG_COUNT 16
`define AXIL_REG_RESET 32'h0000_0000

`endif

/* src/axil_pkg.sv */
`include "axil_macros.svh"

package axil_pkg;

    typedef logic [`AXIL_ADDR_W-1:0]   axil_addr_t;   // Byte address
    typedef logic [`AXIL_DATA_W-1:0]   axil_data_t;
    typedef logic [`AXIL_DATA_W/8-1:0] axil_strb_t;   // One bit per data byte
    typedef logic [1:0]                axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // Master write side
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_SEND,    // AW and W presented together
        WR_RESP
    } wr_state_t;

    // Master read side
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

endpackage

/* src/axil_master.sv */
`timescale 1ns/1ns

module axil_master (
    input  logic                 clk,
    input  logic                 rst_n,
    // User command side
    input  logic                 start_write,
    input  axil_pkg::axil_addr_t write_address,
    input  axil_pkg::axil_data_t write_data,
    input  axil_pkg::axil_strb_t write_strb,
    output logic                 write_done,
    output axil_pkg::axil_resp_t write_resp,
    input  logic                 start_read,
    input  axil_pkg::axil_addr_t read_address,
    output logic                 read_done,
    output axil_pkg::axil_data_t read_data,
    output axil_pkg::axil_resp_t read_resp,
    // AXI4-Lite master side
    output logic                 awvalid,
    input  logic                 awready,
    output axil_pkg::axil_addr_t awaddr,
    output logic                 wvalid,
    input  logic                 wready,
    output axil_pkg::axil_data_t wdata,
    output axil_pkg::axil_strb_t wstrb,
    input  logic                 bvalid,
    output logic                 bready,
    input  axil_pkg::axil_resp_t bresp,
    output logic                 arvalid,
    input  logic                 arready,
    output axil_pkg::axil_addr_t araddr,
    input  logic                 rvalid,
    output logic                 rready,
    input  axil_pkg::axil_data_t rdata,
    input  axil_pkg::axil_resp_t rresp
);
    import axil_pkg::*;

    wr_state_t wr_state;
    wr_state_t wr_next;
    rd_state_t rd_state;
    rd_state_t rd_next;

    logic wr_start;
    logic rd_start;
    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic ar_hs;
    logic r_hs;

    // Starts only count while the direction is idle
    assign wr_start = (wr_state == WR_IDLE) && start_write;
    assign rd_start = (rd_state == RD_IDLE) && start_read;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign b_hs  = bvalid && bready;
    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    assign bready = (wr_state == WR_RESP);
    assign rready = (rd_state == RD_DATA);

    always_comb begin
        wr_next = wr_state;
        case (wr_state)
            WR_IDLE: begin
                if (wr_start)
                    wr_next = WR_SEND;
            end
            WR_SEND: begin
                // A low valid means that channel already went through
                if ((!awvalid || aw_hs) && (!wvalid || w_hs))
                    wr_next = WR_RESP;
            end
            WR_RESP: begin
                if (b_hs)
                    wr_next = WR_IDLE;
            end
            default: wr_next = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state   <= WR_IDLE;
            awvalid    <= 1'b0;
            wvalid     <= 1'b0;
            write_done <= 1'b0;
            write_resp <= RESP_OKAY;
        end else begin
            wr_state   <= wr_next;
            write_done <= b_hs;            // One cycle after B
            if (wr_start) begin
                awvalid <= 1'b1;
                wvalid  <= 1'b1;
            end else begin
                if (aw_hs)
                    awvalid <= 1'b0;
                if (w_hs)
                    wvalid <= 1'b0;
            end
            if (b_hs)
                write_resp <= bresp;
        end
    end

    // Command payload held stable until its handshake
    always_ff @(posedge clk) begin
        if (wr_start) begin
            awaddr <= write_address;
            wdata  <= write_data;
            wstrb  <= write_strb;
        end
        if (rd_start)
            araddr <= read_address;
    end

    always_comb begin
        rd_next = rd_state;
        case (rd_state)
            RD_IDLE: begin
                if (rd_start)
                    rd_next = RD_ADDR;
            end
            RD_ADDR: begin
                if (ar_hs)
                    rd_next = RD_DATA;
            end
            RD_DATA: begin
                if (r_hs)
                    rd_next = RD_IDLE;
            end
            default: rd_next = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state  <= RD_IDLE;
            arvalid   <= 1'b0;
            read_done <= 1'b0;
            read_data <= '0;
            read_resp <= RESP_OKAY;
        end else begin
            rd_state  <= rd_next;
            read_done <= r_hs;
            if (rd_start)
                arvalid <= 1'b1;
            else if (ar_hs)
                arvalid <= 1'b0;
            // Result stays until the next read finishes
            if (r_hs) begin
                read_data <= rdata;
                read_resp <= rresp;
            end
        end
    end

endmodule

/* src/axil_reg_slave.sv */
`timescale 1ns/1ns

`include "axil_macros.svh"

module axil_reg_slave (
    input  logic                 clk,
    input  logic                 rst_n,
    // Write address and data
    input  logic                 awvalid,
    output logic                 awready,
    input  axil_pkg::axil_addr_t awaddr,
    input  logic                 wvalid,
    output logic                 wready,
    input  axil_pkg::axil_data_t wdata,
    input  axil_pkg::axil_strb_t wstrb,
    // Write response
    output logic                 bvalid,
    input  logic                 bready,
    output axil_pkg::axil_resp_t bresp,
    // Read address
    input  logic                 arvalid,
    output logic                 arready,
    input  axil_pkg::axil_addr_t araddr,
    // Read data
    output logic                 rvalid,
    input  logic                 rready,
    output axil_pkg::axil_data_t rdata,
    output axil_pkg::axil_resp_t rresp
);
    import axil_pkg::*;

    axil_data_t regs [`AXIL_REG_COUNT];

    logic       wr_accept;
    logic       rd_accept;
    logic       wr_hs;
    logic       rd_hs;
    logic       wr_in_range;
    logic       rd_in_range;
    logic [3:0] wr_index;
    logic [3:0] rd_index;

    // Word index from bits 5:2, byte offset ignored
    assign wr_index = awaddr[5:2];
    assign rd_index = araddr[5:2];

    // Anything above bit 5 lies outside the register window
    assign wr_in_range = ~|awaddr[`AXIL_ADDR_W-1:6];
    assign rd_in_range = ~|araddr[`AXIL_ADDR_W-1:6];

    // Accept only with no response pending and no ready already up
    assign wr_accept = awvalid && wvalid && !awready && !bvalid;
    assign rd_accept = arvalid && !arready && !rvalid;

    assign wr_hs = awvalid && awready && wvalid && wready;
    assign rd_hs = arvalid && arready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= wr_accept;        // One-cycle pulse
            wready  <= wr_accept;
            arready <= rd_accept;

            if (wr_hs)
                bvalid <= 1'b1;
            else if (bvalid && bready)
                bvalid <= 1'b0;

            if (rd_hs)
                rvalid <= 1'b1;
            else if (rvalid && rready)
                rvalid <= 1'b0;
        end
    end

    // Response payload, captured with the accepted request
    always_ff @(posedge clk) begin
        if (wr_hs)
            bresp <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
        if (rd_hs) begin
            rdata <= rd_in_range ? regs[rd_index] : '0;
            rresp <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Register file with bytewise merge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `AXIL_REG_COUNT; i++)
                regs[i] <= `AXIL_REG_RESET;
        end else if (wr_hs && wr_in_range) begin
            for (int b = 0; b < `AXIL_DATA_W/8; b++) begin
                if (wstrb[b])
                    regs[wr_index][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

endmodule

/* src/axil_subsys_top.sv */
`timescale 1ns/1ns

module axil_subsys_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_write,
    input  axil_pkg::axil_addr_t write_address,
    input  axil_pkg::axil_data_t write_data,
    input  axil_pkg::axil_strb_t write_strb,
    output logic                 write_done,
    output axil_pkg::axil_resp_t write_resp,
    input  logic                 start_read,
    input  axil_pkg::axil_addr_t read_address,
    output logic                 read_done,
    output axil_pkg::axil_data_t read_data,
    output axil_pkg::axil_resp_t read_resp
);
    import axil_pkg::*;

    // AXI4-Lite link between master and slave
    logic       awvalid;
    logic       awready;
    axil_addr_t awaddr;
    logic       wvalid;
    logic       wready;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic       bvalid;
    logic       bready;
    axil_resp_t bresp;
    logic       arvalid;
    logic       arready;
    axil_addr_t araddr;
    logic       rvalid;
    logic       rready;
    axil_data_t rdata;
    axil_resp_t rresp;

    axil_master u_master (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_write   (start_write),
        .write_address (write_address),
        .write_data    (write_data),
        .write_strb    (write_strb),
        .write_done    (write_done),
        .write_resp    (write_resp),
        .start_read    (start_read),
        .read_address  (read_address),
        .read_done     (read_done),
        .read_data     (read_data),
        .read_resp     (read_resp),
        .awvalid       (awvalid),
        .awready       (awready),
        .awaddr        (awaddr),
        .wvalid        (wvalid),
        .wready        (wready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .bvalid        (bvalid),
        .bready        (bready),
        .bresp         (bresp),
        .arvalid       (arvalid),
        .arready       (arready),
        .araddr        (araddr),
        .rvalid        (rvalid),
        .rready        (rready),
        .rdata         (rdata),
        .rresp         (rresp)
    );

    axil_reg_slave u_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

endmodule

/* dv/axil_checker.sv */
`timescale 1ns/1ns

module axil_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 write_done,
    input  axil_pkg::axil_resp_t write_resp,
    input  logic                 read_done,
    input  axil_pkg::axil_data_t read_data,
    input  axil_pkg::axil_resp_t read_resp,
    input  int                   test_num,
    input  logic                 expect_write,
    input  logic                 expect_read,
    input  axil_pkg::axil_data_t exp_rdata,
    input  axil_pkg::axil_resp_t exp_resp,
    input  logic                 test_end,      // Pulse after the last done of a test
    input  logic                 test_aborted,  // Timeout or bad stim line
    output int                   pass_count,
    output int                   fail_count
);
    import axil_pkg::*;

    int errors;     // Mismatches in the current test

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            errors     = 0;
            pass_count = 0;
            fail_count = 0;
        end else begin
            if (write_done) begin
                if (!expect_write) begin
                    $display("Test %0d: write_done pulsed with no write started", test_num);
                    errors++;
                end else if (write_resp !== exp_resp) begin
                    $display("Error: test %0d write_resp = %h, expected %h",
                             test_num, write_resp, exp_resp);
                    errors++;
                end
            end
            if (read_done) begin
                if (!expect_read) begin
                    $display("Test %0d: read_done pulsed with no read started", test_num);
                    errors++;
                end else begin
                    if (read_data !== exp_rdata) begin
                        $display("Error: test %0d read_data = %h, expected %h",
                                 test_num, read_data, exp_rdata);
                        errors++;
                    end
                    if (read_resp !== exp_resp) begin
                        $display("Error: test %0d read_resp = %h, expected %h",
                                 test_num, read_resp, exp_resp);
                        errors++;
                    end
                end
            end
            // Verdict for the test that just ended
            if (test_end) begin
                if (test_aborted)
                    errors++;
                if (errors == 0) begin
                    $display("Test %0d passed", test_num);
                    pass_count++;
                end else begin
                    $display("Test %0d failed with %0d error(s)", test_num, errors);
                    fail_count++;
                end
                errors = 0;
            end
        end
    end

endmodule

/* dv/tb_top.sv */
`timescale 1ns/1ns

module tb_top;
    import axil_pkg::*;

    localparam int MAX_TESTS      = 64;
    localparam int FIELDS         = 7;      // Words per stim line
    localparam int TIMEOUT_CYCLES = 100;

    logic       clk;
    logic       rst_n;
    logic       start_write;
    axil_addr_t write_address;
    axil_data_t write_data;
    axil_strb_t write_strb;
    logic       write_done;
    axil_resp_t write_resp;
    logic       start_read;
    axil_addr_t read_address;
    logic       read_done;
    axil_data_t read_data;
    axil_resp_t read_resp;

    int         test_num;
    logic       expect_write;
    logic       expect_read;
    axil_data_t exp_rdata;
    axil_resp_t exp_resp;
    logic       test_end;
    logic       test_aborted;
    int         pass_count;
    int         fail_count;

    logic [31:0] stim [MAX_TESTS*FIELDS];
    int          num_tests;

    always #5 clk = ~clk;

    axil_subsys_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_write   (start_write),
        .write_address (write_address),
        .write_data    (write_data),
        .write_strb    (write_strb),
        .write_done    (write_done),
        .write_resp    (write_resp),
        .start_read    (start_read),
        .read_address  (read_address),
        .read_done     (read_done),
        .read_data     (read_data),
        .read_resp     (read_resp)
    );

    axil_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .write_done   (write_done),
        .write_resp   (write_resp),
        .read_done    (read_done),
        .read_data    (read_data),
        .read_resp    (read_resp),
        .test_num     (test_num),
        .expect_write (expect_write),
        .expect_read  (expect_read),
        .exp_rdata    (exp_rdata),
        .exp_resp     (exp_resp),
        .test_end     (test_end),
        .test_aborted (test_aborted),
        .pass_count   (pass_count),
        .fail_count   (fail_count)
    );

    // An op of zero marks the end of the table
    task automatic load_stim();
        for (int i = 0; i < MAX_TESTS*FIELDS; i++)
            stim[i] = '0;
        $readmemh("dv/axil_stim.txt", stim);
        num_tests = 0;
        while (num_tests < MAX_TESTS && stim[num_tests*FIELDS] != 0)
            num_tests++;
    endtask

    task automatic wait_done(input logic want_wr, input logic want_rd, output logic ok);
        logic got_wr;
        logic got_rd;
        int   cycles;
        got_wr = !want_wr;
        got_rd = !want_rd;
        cycles = 0;
        while (!(got_wr && got_rd) && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            if (write_done)
                got_wr = 1'b1;
            if (read_done)
                got_rd = 1'b1;
            cycles++;
        end
        if (!got_wr)
            $display("Test %0d: write did not complete within %0d cycles", test_num, cycles);
        if (!got_rd)
            $display("Test %0d: read did not complete within %0d cycles", test_num, cycles);
        ok = got_wr && got_rd;
    endtask

    task automatic run_test(input int idx);
        int   op;
        logic ok;
        op = stim[idx*FIELDS];
        @(negedge clk);
        test_num      = idx + 1;
        expect_write  = (op == 1 || op == 3);
        expect_read   = (op == 2 || op == 3);
        write_address = stim[idx*FIELDS + 1];
        write_data    = stim[idx*FIELDS + 2];
        write_strb    = stim[idx*FIELDS + 3][3:0];
        read_address  = stim[idx*FIELDS + 4];
        exp_rdata     = stim[idx*FIELDS + 5];
        exp_resp      = stim[idx*FIELDS + 6][1:0];  // Shared by both directions
        if (op < 1 || op > 3) begin
            $display("Test %0d: unknown operation %0d in stim file", test_num, op);
            ok = 1'b0;
        end else begin
            start_write = expect_write;
            start_read  = expect_read;
            @(negedge clk);
            start_write = 1'b0;
            start_read  = 1'b0;
            wait_done(expect_write, expect_read, ok);
        end
        test_aborted = !ok;
        @(negedge clk);
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        start_write   = 1'b0;
        write_address = '0;
        write_data    = '0;
        write_strb    = '0;
        start_read    = 1'b0;
        read_address  = '0;
        test_num      = 0;
        expect_write  = 1'b0;
        expect_read   = 1'b0;
        exp_rdata     = '0;
        exp_resp      = '0;
        test_end      = 1'b0;
        test_aborted  = 1'b0;
        load_stim();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < num_tests; i++)
            run_test(i);
        if (num_tests == 0)
            $display("No tests could be read from dv/axil_stim.txt");
        $display("Tests run: %0d  passed: %0d  failed: %0d", num_tests, pass_count, fail_count);
        if (num_tests > 0 && fail_count == 0 && pass_count == num_tests) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* dv/axil_stim.txt */
// op (1 write, 2 read, 3 write and read together), write address, write data,
// strobe, read address, expected read data, expected response (both directions)
2 00000000 00000000 0 00000000 00000000 0
2 00000000 00000000 0 00000004 00000000 0
2 00000000 00000000 0 00000008 00000000 0
2 00000000 00000000 0 0000000c 00000000 0
2 00000000 00000000 0 00000010 00000000 0
2 00000000 00000000 0 00000014 00000000 0
2 00000000 00000000 0 00000018 00000000 0
2 00000000 00000000 0 0000001c 00000000 0
2 00000000 00000000 0 00000020 00000000 0
2 00000000 00000000 0 00000024 00000000 0
2 00000000 00000000 0 00000028 00000000 0
2 00000000 00000000 0 0000002c 00000000 0
2 00000000 00000000 0 00000030 00000000 0
2 00000000 00000000 0 00000034 00000000 0
2 00000000 00000000 0 00000038 00000000 0
2 00000000 00000000 0 0000003c 00000000 0
1 00000004 12345678 f 00000000 00000000 0
2 00000000 00000000 0 00000004 12345678 0
1 00000008 a5a5a5a5 f 00000000 00000000 0
1 00000008 11223344 5 00000000 00000000 0
2 00000000 00000000 0 00000008 a522a544 0
1 0000000d cafef00d f 00000000 00000000 0
2 00000000 00000000 0 0000000c cafef00d 0
1 00000040 deadbeef f 00000000 00000000 2
2 00000000 00000000 0 00000000 00000000 0
2 00000000 00000000 0 00000100 00000000 2
3 00000010 0badc0de f 00000004 12345678 0
2 00000000 00000000 0 00000010 0badc0de 0

/* build.f */
+incdir+src
src/axil_pkg.sv
src/axil_master.sv
src/axil_reg_slave.sv
src/axil_subsys_top.sv
dv/axil_checker.sv
dv/tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_top -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Regression failed" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"
